// File: logic/apb_delay_pkg.sv
package apb_delay_pkg;

    // ------------------------------------------------------------------
    // APB bus widths
    // ------------------------------------------------------------------
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;
    localparam int PROT_WIDTH = 3;

    // ------------------------------------------------------------------
    // Peripheral and delayer defaults
    // ------------------------------------------------------------------
    localparam int REG_COUNT_DEFAULT = 16;
    localparam int WAIT_REG_INDEX = 15;
    localparam int WAIT_WIDTH = 6;             // Low bits of the wait register.

    localparam int RATIO_FRAC_DEFAULT = 10;
    localparam int DELAY_RATIO_DEFAULT = 2048; // 2.0 in 10 fraction bits.
    localparam int COUNT_WIDTH_DEFAULT = 32;

    // ------------------------------------------------------------------
    // State encodings
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        DELAYER_IDLE,
        DELAYER_ACTIVE,
        DELAYER_DELAY
    } delayer_state_t;

    typedef enum logic [1:0] {
        REGS_IDLE,
        REGS_WAIT,
        REGS_RESPOND
    } regs_state_t;

endpackage

// File: logic/apb_scratch_regs.sv
module apb_scratch_regs #(
    parameter int REG_COUNT = apb_delay_pkg::REG_COUNT_DEFAULT
) (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic [apb_delay_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic [apb_delay_pkg::PROT_WIDTH-1:0] pprot,
    input  logic                                 pwrite,
    input  logic [apb_delay_pkg::DATA_WIDTH-1:0] pwdata,
    input  logic [apb_delay_pkg::STRB_WIDTH-1:0] pstrb,
    output logic                                 pready,
    output logic [apb_delay_pkg::DATA_WIDTH-1:0] prdata,
    output logic                                 pslverr
);

    localparam int IDX_WIDTH = $clog2(REG_COUNT);
    localparam int IDX_MSB   = IDX_WIDTH + 1;   // Word index sits above byte offset.

    apb_delay_pkg::regs_state_t state;

    logic [apb_delay_pkg::DATA_WIDTH-1:0] regs [REG_COUNT];
    logic [apb_delay_pkg::WAIT_WIDTH-1:0] wait_cnt;
    logic [apb_delay_pkg::WAIT_WIDTH-1:0] wait_value;
    logic [IDX_WIDTH-1:0]                 idx;
    logic                                 addr_err;
    logic                                 setup;

    assign idx        = paddr[IDX_MSB:2];
    assign addr_err   = (|paddr[apb_delay_pkg::ADDR_WIDTH-1:IDX_MSB+1]) | (|paddr[1:0]);
    assign wait_value = regs[apb_delay_pkg::WAIT_REG_INDEX][apb_delay_pkg::WAIT_WIDTH-1:0];
    assign setup      = psel & ~penable;

    // ------------------------------------------------------------------
    // Wait-state FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= apb_delay_pkg::REGS_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                apb_delay_pkg::REGS_IDLE: begin
                    if (setup) begin
                        wait_cnt <= wait_value;
                        if (wait_value == '0) begin
                            state <= apb_delay_pkg::REGS_RESPOND;
                        end else begin
                            state <= apb_delay_pkg::REGS_WAIT;
                        end
                    end
                end
                apb_delay_pkg::REGS_WAIT: begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (wait_cnt == apb_delay_pkg::WAIT_WIDTH'(1)) begin
                        state <= apb_delay_pkg::REGS_RESPOND;
                    end
                end
                apb_delay_pkg::REGS_RESPOND: state <= apb_delay_pkg::REGS_IDLE;
                default: state <= apb_delay_pkg::REGS_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Response and register file
    // ------------------------------------------------------------------
    assign pready  = (state == apb_delay_pkg::REGS_RESPOND);
    assign pslverr = pready & addr_err;
    assign prdata  = (pready && !pwrite && !addr_err) ? regs[idx] : '0;

    // Writes land at the end of the ready cycle.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (pready && pwrite && !addr_err) begin
            for (int b = 0; b < apb_delay_pkg::STRB_WIDTH; b++) begin
                if (pstrb[b]) begin
                    regs[idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

    // Completion only inside an access phase of the requester.
    assert property (@(posedge clock) disable iff (reset)
        pready |-> psel && penable)
        else $error("apb_scratch_regs: pready outside access phase");

    // Requester keeps the transfer stable while waiting.
    assert property (@(posedge clock) disable iff (reset)
        psel && penable |-> $stable({paddr, pprot, pwrite, pwdata, pstrb}))
        else $error("apb_scratch_regs: request changed during access");

endmodule

// File: logic/apb_delayer.sv
module apb_delayer #(
    parameter int DELAY_RATIO = apb_delay_pkg::DELAY_RATIO_DEFAULT,
    parameter int RATIO_FRAC  = apb_delay_pkg::RATIO_FRAC_DEFAULT,
    parameter int COUNT_WIDTH = apb_delay_pkg::COUNT_WIDTH_DEFAULT
) (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic [apb_delay_pkg::ADDR_WIDTH-1:0] in_paddr,
    input  logic                                 in_psel,
    input  logic                                 in_penable,
    input  logic [apb_delay_pkg::PROT_WIDTH-1:0] in_pprot,
    input  logic                                 in_pwrite,
    input  logic [apb_delay_pkg::DATA_WIDTH-1:0] in_pwdata,
    input  logic [apb_delay_pkg::STRB_WIDTH-1:0] in_pstrb,
    output logic                                 in_pready,
    output logic [apb_delay_pkg::DATA_WIDTH-1:0] in_prdata,
    output logic                                 in_pslverr,

    output logic [apb_delay_pkg::ADDR_WIDTH-1:0] out_paddr,
    output logic                                 out_psel,
    output logic                                 out_penable,
    output logic [apb_delay_pkg::PROT_WIDTH-1:0] out_pprot,
    output logic                                 out_pwrite,
    output logic [apb_delay_pkg::DATA_WIDTH-1:0] out_pwdata,
    output logic [apb_delay_pkg::STRB_WIDTH-1:0] out_pstrb,
    input  logic                                 out_pready,
    input  logic [apb_delay_pkg::DATA_WIDTH-1:0] out_prdata,
    input  logic                                 out_pslverr
);

    localparam int ACC_WIDTH = 2 * COUNT_WIDTH;
    localparam logic [ACC_WIDTH-1:0] RATIO_STEP = ACC_WIDTH'(DELAY_RATIO);

    apb_delay_pkg::delayer_state_t state;

    logic [COUNT_WIDTH-1:0] wait_cnt;   // Downstream wait cycles seen.
    logic [ACC_WIDTH-1:0]   acc;        // wait_cnt times ratio, fixed point.
    logic [COUNT_WIDTH-1:0] extra_cnt;
    logic [ACC_WIDTH-1:0]   scaled;
    logic [ACC_WIDTH-1:0]   wait_ext;
    logic [ACC_WIDTH-1:0]   diff;
    logic [COUNT_WIDTH-1:0] extra_next;

    logic [apb_delay_pkg::DATA_WIDTH-1:0] held_prdata;
    logic                                 held_pslverr;

    logic in_setup;
    logic in_delay;
    logic delay_done;

    assign in_setup   = in_psel & ~in_penable;
    assign in_delay   = (state == apb_delay_pkg::DELAYER_DELAY);
    assign delay_done = in_delay & (extra_cnt == '0);

    // ------------------------------------------------------------------
    // Downstream request, blocked while stretching
    // ------------------------------------------------------------------
    assign out_paddr   = in_paddr;
    assign out_psel    = in_psel & ~in_delay;
    assign out_penable = in_penable & ~in_delay;
    assign out_pprot   = in_pprot;
    assign out_pwrite  = in_pwrite;
    assign out_pwdata  = in_pwdata;
    assign out_pstrb   = in_pstrb;

    // Extra delay, clamped at zero for ratios below one.
    assign scaled     = acc >> RATIO_FRAC;
    assign wait_ext   = {{(ACC_WIDTH - COUNT_WIDTH){1'b0}}, wait_cnt};
    assign diff       = scaled - wait_ext;
    assign extra_next = (scaled > wait_ext) ? diff[COUNT_WIDTH-1:0] : '0;

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= apb_delay_pkg::DELAYER_IDLE;
        end else begin
            case (state)
                apb_delay_pkg::DELAYER_IDLE: begin
                    if (in_setup) begin
                        state <= apb_delay_pkg::DELAYER_ACTIVE;
                    end
                end
                apb_delay_pkg::DELAYER_ACTIVE: begin
                    if (out_pready) begin
                        state <= apb_delay_pkg::DELAYER_DELAY;
                    end
                end
                apb_delay_pkg::DELAYER_DELAY: begin
                    if (delay_done) begin
                        state <= apb_delay_pkg::DELAYER_IDLE;
                    end
                end
                default: state <= apb_delay_pkg::DELAYER_IDLE;
            endcase
        end
    end

    // Measure, then count the extra cycles down.
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt  <= '0;
            acc       <= '0;
            extra_cnt <= '0;
        end else if (state == apb_delay_pkg::DELAYER_ACTIVE) begin
            if (out_pready) begin
                extra_cnt <= extra_next;
                wait_cnt  <= '0;
                acc       <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
                acc      <= acc + RATIO_STEP;
            end
        end else if (in_delay && extra_cnt != '0) begin
            extra_cnt <= extra_cnt - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (state == apb_delay_pkg::DELAYER_ACTIVE && out_pready) begin
            held_prdata  <= out_prdata;
            held_pslverr <= out_pslverr;
        end
    end

    // ------------------------------------------------------------------
    // Upstream completion, one cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            in_pready  <= 1'b0;
            in_prdata  <= '0;
            in_pslverr <= 1'b0;
        end else if (delay_done) begin
            in_pready  <= 1'b1;
            in_prdata  <= held_prdata;
            in_pslverr <= held_pslverr;
        end else begin
            in_pready  <= 1'b0;
            in_prdata  <= '0;
            in_pslverr <= 1'b0;
        end
    end

    // The peripheral stays quiet while the completion is held back.
    assert property (@(posedge clock) disable iff (reset)
        in_delay |-> !out_penable && !out_pready)
        else $error("apb_delayer: downstream access during delay");

    assert property (@(posedge clock) disable iff (reset)
        in_pready |=> !in_pready)
        else $error("apb_delayer: in_pready high two cycles in a row");

endmodule

// File: logic/apb_delay_top.sv
module apb_delay_top #(
    parameter int DELAY_RATIO = apb_delay_pkg::DELAY_RATIO_DEFAULT,
    parameter int RATIO_FRAC  = apb_delay_pkg::RATIO_FRAC_DEFAULT,
    parameter int COUNT_WIDTH = apb_delay_pkg::COUNT_WIDTH_DEFAULT,
    parameter int REG_COUNT   = apb_delay_pkg::REG_COUNT_DEFAULT
) (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic [apb_delay_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic [apb_delay_pkg::PROT_WIDTH-1:0] pprot,
    input  logic                                 pwrite,
    input  logic [apb_delay_pkg::DATA_WIDTH-1:0] pwdata,
    input  logic [apb_delay_pkg::STRB_WIDTH-1:0] pstrb,
    output logic                                 pready,
    output logic [apb_delay_pkg::DATA_WIDTH-1:0] prdata,
    output logic                                 pslverr
);

    // Delayer to peripheral.
    logic [apb_delay_pkg::ADDR_WIDTH-1:0] dev_paddr;
    logic                                 dev_psel;
    logic                                 dev_penable;
    logic [apb_delay_pkg::PROT_WIDTH-1:0] dev_pprot;
    logic                                 dev_pwrite;
    logic [apb_delay_pkg::DATA_WIDTH-1:0] dev_pwdata;
    logic [apb_delay_pkg::STRB_WIDTH-1:0] dev_pstrb;
    logic                                 dev_pready;
    logic [apb_delay_pkg::DATA_WIDTH-1:0] dev_prdata;
    logic                                 dev_pslverr;

    apb_delayer #(
        .DELAY_RATIO (DELAY_RATIO),
        .RATIO_FRAC  (RATIO_FRAC),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_delayer (
        .clock       (clock),
        .reset       (reset),
        .in_paddr    (paddr),
        .in_psel     (psel),
        .in_penable  (penable),
        .in_pprot    (pprot),
        .in_pwrite   (pwrite),
        .in_pwdata   (pwdata),
        .in_pstrb    (pstrb),
        .in_pready   (pready),
        .in_prdata   (prdata),
        .in_pslverr  (pslverr),
        .out_paddr   (dev_paddr),
        .out_psel    (dev_psel),
        .out_penable (dev_penable),
        .out_pprot   (dev_pprot),
        .out_pwrite  (dev_pwrite),
        .out_pwdata  (dev_pwdata),
        .out_pstrb   (dev_pstrb),
        .out_pready  (dev_pready),
        .out_prdata  (dev_prdata),
        .out_pslverr (dev_pslverr)
    );

    apb_scratch_regs #(
        .REG_COUNT (REG_COUNT)
    ) i_regs (
        .clock   (clock),
        .reset   (reset),
        .paddr   (dev_paddr),
        .psel    (dev_psel),
        .penable (dev_penable),
        .pprot   (dev_pprot),
        .pwrite  (dev_pwrite),
        .pwdata  (dev_pwdata),
        .pstrb   (dev_pstrb),
        .pready  (dev_pready),
        .prdata  (dev_prdata),
        .pslverr (dev_pslverr)
    );

endmodule

// File: bench/apb_delay_tb.sv
module apb_delay_tb;

    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int TRANSFERS      = 400;
    localparam logic [31:0] SEED  = 32'hefd94617;

    logic                                 clock;
    logic                                 reset;
    logic [apb_delay_pkg::ADDR_WIDTH-1:0] paddr;
    logic                                 psel;
    logic                                 penable;
    logic [apb_delay_pkg::PROT_WIDTH-1:0] pprot;
    logic                                 pwrite;
    logic [apb_delay_pkg::DATA_WIDTH-1:0] pwdata;
    logic [apb_delay_pkg::STRB_WIDTH-1:0] pstrb;
    logic                                 pready;
    logic [apb_delay_pkg::DATA_WIDTH-1:0] prdata;
    logic                                 pslverr;

    logic [31:0]                          rng_state;
    logic [apb_delay_pkg::DATA_WIDTH-1:0] model_regs [apb_delay_pkg::REG_COUNT_DEFAULT];

    apb_delay_top i_dut (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ------------------------------------------------------------------
    // Random numbers, reference timing, checks
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Longer of w and w times the ratio, plus three cycles of overhead.
    function automatic int expected_length(input int w);
        longint scaled;
        scaled = (longint'(w) * apb_delay_pkg::DELAY_RATIO_DEFAULT)
                 >>> apb_delay_pkg::RATIO_FRAC_DEFAULT;
        return ((scaled > w) ? int'(scaled) : w) + 3;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name,
                              input logic [apb_delay_pkg::DATA_WIDTH-1:0] actual,
                              input logic [apb_delay_pkg::DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_error(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected) begin
            fail_run($sformatf("error: %s got %h expected %h", name, actual, expected));
        end
    endtask

    // No response outside the single ready cycle.
    task automatic check_quiet();
        check_error("pready", pready, 1'b0);
        check_data("prdata", prdata, '0);
        check_error("pslverr", pslverr, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // Bus driving
    // ------------------------------------------------------------------
    task automatic idle_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
        check_quiet();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic do_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               input logic [2:0] prot, output logic [31:0] rdata,
                               output logic err, output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;
        check_quiet();          // Previous transfer ended after one ready cycle.
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        pstrb   = strb;
        pprot   = prot;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;
        check_quiet();
        penable = 1'b1;
        while (!done) begin
            cycles = cycles + 1;
            if (pready === 1'b1) begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end else begin
                check_quiet();
                if (cycles >= TIMEOUT_CYCLES) begin
                    fail_run($sformatf("pready never came within %0d access cycles",
                                       TIMEOUT_CYCLES));
                end else begin
                    @(posedge clock);
                    #DRIVE_DELAY;
                end
            end
        end
    endtask

    // One transfer checked against the register model.
    task automatic run_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                input logic [2:0] prot);
        logic [31:0] rdata;
        logic [31:0] exp_data;
        logic        err;
        logic        exp_err;
        logic [3:0]  idx;
        int          cycles;
        int          w;
        idx      = addr[5:2];
        exp_err  = (addr[31:6] != '0) || (addr[1:0] != 2'b00);
        w        = int'(model_regs[apb_delay_pkg::WAIT_REG_INDEX][5:0]);
        exp_data = (write || exp_err) ? '0 : model_regs[idx];
        do_transfer(write, addr, wdata, strb, prot, rdata, err, cycles);
        check_data("prdata", rdata, exp_data);
        check_error("pslverr", err, exp_err);
        check_latency("access cycles", cycles, expected_length(w));
        if (write && !exp_err) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model_regs[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  idx;
        logic [3:0]  strb;
        logic        write;
        int          shamt;
        rng_state = SEED;
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pprot     = '0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        for (int i = 0; i < apb_delay_pkg::REG_COUNT_DEFAULT; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Reset values, all with zero wait states.
        for (int i = 0; i < apb_delay_pkg::REG_COUNT_DEFAULT; i++) begin
            run_transfer(1'b0, 32'(i * 4), '0, '0, '0);
        end

        for (int n = 0; n < TRANSFERS; n++) begin
            r     = next_random();
            idx   = r[7:4];
            write = r[8];
            strb  = 4'(next_random());
            data  = next_random();
            if (r[3:0] == 4'd0) begin
                data = next_random() % 32'd13;      // New wait count.
                run_transfer(1'b1, {26'd0, 4'd15, 2'b00}, data, 4'hf, r[11:9]);
            end else if (r[3:0] < 4'd3) begin
                addr = {26'd0, idx, 2'b00};
                if (r[12]) begin
                    shamt = 6 + int'(r[20:16]) % 26;
                    addr  = addr | (32'd1 << shamt);
                end else begin
                    addr = addr | {30'd0, (r[14:13] == 2'b00) ? 2'b01 : r[14:13]};
                end
                run_transfer(write, addr, data, strb, r[11:9]);
            end else begin
                if (write && idx == 4'd15) begin
                    idx = 4'd14;                    // Wait register has its own path.
                end
                run_transfer(write, {26'd0, idx, 2'b00}, data, strb, r[11:9]);
            end
            repeat (int'(r[22:21])) idle_cycle();
        end

        idle_cycle();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: files.f
logic/apb_delay_pkg.sv
logic/apb_scratch_regs.sv
logic/apb_delayer.sv
logic/apb_delay_top.sv
bench/apb_delay_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the APB delayer simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module apb_delay_tb -o apb_delay_sim

output=$(./obj_dir/apb_delay_sim) || true
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
